//--- colmix/colour_mixer.sv
// layer priority mux, blanking gated palette address and the four proms of the colour stage
`timescale 1ns/100ps

module colour_mixer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cen6,
    input  colmix_pkg::layer_pixels_t pixels,
    input  colmix_pkg::video_sync_t   sync,
    input  colmix_pkg::prom_write_t   prom_wr,
    output colmix_pkg::rgb_t          rgb
);

    colmix_pkg::prom_addr_t pixel_mux;    // address before blanking
    colmix_pkg::prom_addr_t addr_reg;     // address seen by all proms
    colmix_pkg::colour_t    sel_q;        // select prom output, previous pixel

    // priority mux driven by the select prom
    always_comb begin
        pixel_mux[7:6] = sel_q[3:2];      // palette bank
        case (sel_q[1:0])
            2'b00:   pixel_mux[5:0] = pixels.scr2_pxl;
            2'b01:   pixel_mux[5:0] = pixels.scr1_pxl;
            2'b10:   pixel_mux[5:0] = pixels.obj_pxl;
            default: pixel_mux[5:0] = {2'b00, pixels.char_pxl};   // char is 4 bits
        endcase
    end

    // blanking forces entry 0
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_reg <= '0;
        end else if (cen6) begin
            addr_reg <= (sync.lhbl && sync.lvbl) ? pixel_mux : '0;
        end
    end

    // colour guns
    palette_prom #(.PROM_SEL(0)) u_red (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen6),
        .rd_addr (addr_reg),
        .wr      (prom_wr),
        .q       (rgb.red)
    );

    palette_prom #(.PROM_SEL(1)) u_green (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen6),
        .rd_addr (addr_reg),
        .wr      (prom_wr),
        .q       (rgb.green)
    );

    palette_prom #(.PROM_SEL(2)) u_blue (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen6),
        .rd_addr (addr_reg),
        .wr      (prom_wr),
        .q       (rgb.blue)
    );

    // priority prom, read at the same address and fed back into the mux
    palette_prom #(.PROM_SEL(3)) u_select (
        .clk     (clk),
        .reset   (reset),
        .cen     (cen6),
        .rd_addr (addr_reg),
        .wr      (prom_wr),
        .q       (sel_q)
    );

endmodule

//--- colmix/palette_prom.sv
// one 256x4 writable prom with a registered read port, used by the colour mixer
`timescale 1ns/100ps

module palette_prom #(
    parameter int PROM_SEL = 0        // which write strobe this prom answers to
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cen,
    input  colmix_pkg::prom_addr_t  rd_addr,
    input  colmix_pkg::prom_write_t wr,
    output colmix_pkg::colour_t     q
);

    colmix_pkg::colour_t mem [colmix_pkg::PROM_DEPTH];

    // programming port, full clk rate
    always_ff @(posedge clk) begin
        if (wr.we[PROM_SEL]) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read register, advances once per pixel
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

//--- common/colmix_pkg.sv
// shared widths, bus structs and constants for the colour mixing stage, referenced by scoped names
package colmix_pkg;

    // prom geometry
    localparam int PROM_AW    = 8;                  // address bits per prom
    localparam int PROM_DW    = 4;                  // data bits per prom
    localparam int PROM_DEPTH = 256;                // entries per prom
    localparam int PROM_COUNT = 4;                  // red, green, blue, select
    localparam int LOAD_IW    = 10;                 // 2 prom select bits over the address

    // plain vector types with a meaning
    typedef logic [3:0]         char_pxl_t;         // character colour code
    typedef logic [5:0]         layer_pxl_t;        // scroll / object pixel code
    typedef logic [PROM_DW-1:0] colour_t;           // one gun, also prom data and nibble
    typedef logic [PROM_AW-1:0] prom_addr_t;        // palette address
    typedef logic [LOAD_IW-1:0] load_index_t;       // running nibble index

    // last nibble of the programming stream, end of select prom
    localparam load_index_t LOAD_LAST = load_index_t'(PROM_DEPTH * PROM_COUNT - 1);

    // the four layers coming from the tile and sprite generators
    typedef struct packed {
        char_pxl_t  char_pxl;
        layer_pxl_t scr1_pxl;
        layer_pxl_t scr2_pxl;
        layer_pxl_t obj_pxl;
    } layer_pixels_t;                               // 22 bits

    // colour output
    typedef struct packed {
        colour_t red;
        colour_t green;
        colour_t blue;
    } rgb_t;                                        // 12 bits

    // blanking flags, both high during active video
    typedef struct packed {
        logic lhbl;                                 // 1 = horizontal active
        logic lvbl;                                 // 1 = vertical active
    } video_sync_t;

    // prom write port shared by all four proms
    typedef struct packed {
        prom_addr_t            addr;
        colour_t               data;
        logic [PROM_COUNT-1:0] we;                  // bit 0 red .. bit 3 select
    } prom_write_t;                                 // 16 bits

    // loader fsm
    typedef enum logic {
        LOAD_RUN,
        LOAD_DONE
    } load_state_t;

endpackage

//--- sim/tb_clock.sv
// clock and power-on reset source for the colour mixer testbench, instantiated by tb_colmix
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD       = 40,  // ns
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // reset drops 2 ns after an edge, same as the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
    end

endmodule

//--- sim/tb_colmix.sv
// testbench for video_colmix_top: loads the proms, runs video and checks rgb against a model
`timescale 1ns/100ps

module tb_colmix;

    localparam int CLK_PERIOD   = 40;
    localparam int H_TOT        = 24;                 // short lines and frames so blanking comes often
    localparam int H_ACT        = 16;
    localparam int V_TOT        = 6;
    localparam int V_ACT        = 4;
    localparam int LOAD_LEN     = 1024;               // 4 proms x 256 nibbles
    localparam int FRAME_PULSES = H_TOT * V_TOT;
    localparam int CONVERGE     = H_TOT + 4;          // pulses until unloaded x values are flushed
    localparam int RUN_PULSES   = 6 * FRAME_PULSES;   // video pulses after load_done
    localparam int WATCHDOG_CYCLES = LOAD_LEN * 3 + 8 * FRAME_PULSES * 4 + 200;

    logic                      clk;
    logic                      reset;
    colmix_pkg::layer_pixels_t pixels;
    logic                      prog_valid;
    colmix_pkg::colour_t       prog_data;
    logic                      prog_ready;
    logic                      load_done;
    logic                      cen6;
    colmix_pkg::video_sync_t   sync;
    colmix_pkg::rgb_t          rgb;

    logic [31:0]             lfsr;                   // stimulus random source
    colmix_pkg::colour_t     ref_prom [4][256];      // red, green, blue, select
    int                      xfer_count = 0;         // transfers seen on the stream
    int                      video_pulses = 0;       // cen6 pulses since load_done
    colmix_pkg::prom_write_t exp_wr;                 // write expected on the next transfer
    int                      m_h;                    // model h/v counts
    int                      m_v;
    colmix_pkg::prom_addr_t  m_addr;                 // model address register
    colmix_pkg::colour_t     m_sel;                  // model select prom output
    colmix_pkg::rgb_t        m_rgb;
    colmix_pkg::rgb_t        prom0_rgb;              // colour at palette entry 0
    logic                    exp_lhbl;
    logic                    exp_lvbl;
    logic                    check_en;
    logic [3:0]              sel_seen = '0;          // select codes hit in active video

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) u_clock (
        .clk   (clk),
        .reset (reset)
    );

    video_colmix_top #(
        .H_TOTAL  (H_TOT),
        .H_ACTIVE (H_ACT),
        .V_TOTAL  (V_TOT),
        .V_ACTIVE (V_ACT)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .pixels     (pixels),
        .prog_valid (prog_valid),
        .prog_data  (prog_data),
        .prog_ready (prog_ready),
        .load_done  (load_done),
        .cen6       (cen6),
        .sync       (sync),
        .rgb        (rgb)
    );

    // prints the error line and the fail message then stops
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // priority mux with select bits 3:2 as the bank and 1:0 as the layer
    function automatic colmix_pkg::prom_addr_t layer_address(
        input colmix_pkg::colour_t       sel,
        input colmix_pkg::layer_pixels_t px
    );
        colmix_pkg::layer_pxl_t low;
        case (sel[1:0])
            2'b00:   low = px.scr2_pxl;
            2'b01:   low = px.scr1_pxl;
            2'b10:   low = px.obj_pxl;
            default: low = {2'b00, px.char_pxl};
        endcase
        return {sel[3:2], low};
    endfunction

    // nibble k -> prom k/256, address k%256
    always_comb begin
        exp_wr = '0;
        if (xfer_count < LOAD_LEN) begin
            exp_wr.addr = colmix_pkg::prom_addr_t'(xfer_count % 256);
            exp_wr.data = ref_prom[xfer_count / 256][xfer_count % 256];
            exp_wr.we   = 4'b0001 << (xfer_count / 256);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            xfer_count <= 0;
        end else if (prog_valid && prog_ready) begin
            xfer_count <= xfer_count + 1;
        end
    end

    // reference model paced by the dut's cen6
    always @(posedge clk) begin
        if (reset) begin
            m_h    <= 0;
            m_v    <= 0;
            m_addr <= '0;
            m_sel  <= '0;
            m_rgb  <= '0;
        end else if (cen6) begin
            m_h <= (m_h == H_TOT - 1) ? 0 : m_h + 1;
            if (m_h == H_TOT - 1) begin
                m_v <= (m_v == V_TOT - 1) ? 0 : m_v + 1;   // line wrap steps the frame
            end
            m_rgb  <= {ref_prom[0][m_addr], ref_prom[1][m_addr], ref_prom[2][m_addr]};
            m_sel  <= ref_prom[3][m_addr];
            m_addr <= (exp_lhbl && exp_lvbl) ? layer_address(m_sel, pixels) : '0;
            if (load_done) begin
                video_pulses <= video_pulses + 1;
            end
            if (check_en && exp_lhbl && exp_lvbl) begin
                sel_seen[m_sel[1:0]] <= 1'b1;
            end
        end
    end

    assign exp_lhbl  = (m_h < H_ACT);
    assign exp_lvbl  = (m_v < V_ACT);
    assign check_en  = (video_pulses >= CONVERGE);
    assign prom0_rgb = {ref_prom[0][0], ref_prom[1][0], ref_prom[2][0]};

    a_reset: assert property (@(posedge clk)
        $fell(reset) |-> (rgb == '0 && !load_done && prog_ready))
        else abort_run($sformatf(
            "MISMATCH time %0t rgb/load_done/prog_ready expected 000/0/1 actual %h/%b/%b",
            $time, $sampled(rgb), $sampled(load_done), $sampled(prog_ready)));

    // each transfer writes exactly one nibble at its slot
    a_write: assert property (@(posedge clk) disable iff (reset)
        (prog_valid && prog_ready) |-> (DUT.prom_wr == exp_wr))
        else abort_run($sformatf("MISMATCH time %0t prom_wr expected %h actual %h",
            $time, $sampled(exp_wr), $sampled(DUT.prom_wr)));

    a_no_write: assert property (@(posedge clk) disable iff (reset)
        !(prog_valid && prog_ready) |-> (DUT.prom_wr.we == '0))
        else abort_run($sformatf("prom write strobe set without a transfer at %0t", $time));

    a_done_count: assert property (@(posedge clk) disable iff (reset)
        load_done == (xfer_count == LOAD_LEN))
        else abort_run($sformatf("MISMATCH time %0t load_done expected %b actual %b",
            $time, $sampled(xfer_count == LOAD_LEN), $sampled(load_done)));

    a_ready: assert property (@(posedge clk) disable iff (reset)
        prog_ready == (xfer_count < LOAD_LEN))
        else abort_run($sformatf("MISMATCH time %0t prog_ready expected %b actual %b",
            $time, $sampled(xfer_count < LOAD_LEN), $sampled(prog_ready)));

    a_done_rise: assert property (@(posedge clk) disable iff (reset)
        (prog_valid && prog_ready && xfer_count == LOAD_LEN - 1) |=> (load_done && !prog_ready))
        else abort_run($sformatf("load_done did not rise after the last transfer at %0t", $time));

    a_done_stay: assert property (@(posedge clk) disable iff (reset)
        load_done |=> (load_done && !prog_ready))
        else abort_run($sformatf("load_done or prog_ready changed after loading at %0t", $time));

    a_cen_first: assert property (@(posedge clk) $fell(reset) |=> cen6)
        else abort_run($sformatf("cen6 missing on the first clk after reset at %0t", $time));

    a_cen_rate: assert property (@(posedge clk) disable iff (reset)
        cen6 |=> !cen6 ##1 !cen6 ##1 !cen6 ##1 cen6)
        else abort_run($sformatf("cen6 not high exactly one clk in four at %0t", $time));

    a_lhbl: assert property (@(posedge clk) disable iff (reset) sync.lhbl == exp_lhbl)
        else abort_run($sformatf("MISMATCH time %0t sync.lhbl expected %b actual %b",
            $time, $sampled(exp_lhbl), $sampled(sync.lhbl)));

    a_lvbl: assert property (@(posedge clk) disable iff (reset) sync.lvbl == exp_lvbl)
        else abort_run($sformatf("MISMATCH time %0t sync.lvbl expected %b actual %b",
            $time, $sampled(exp_lvbl), $sampled(sync.lvbl)));

    a_rgb: assert property (@(posedge clk) disable iff (reset) check_en |-> (rgb == m_rgb))
        else abort_run($sformatf("MISMATCH time %0t rgb expected %h actual %h",
            $time, $sampled(m_rgb), $sampled(rgb)));

    // blank sampled at one pulse shows entry 0 after the next
    a_blank: assert property (@(posedge clk) disable iff (reset)
        (check_en && cen6 && !(exp_lhbl && exp_lvbl)) |-> ##5 (rgb == prom0_rgb))
        else abort_run($sformatf("MISMATCH time %0t rgb in blanking expected %h actual %h",
            $time, $sampled(prom0_rgb), $sampled(rgb)));

    for (genvar g = 0; g < 4; g++) begin : g_sel_cover
        c_sel: cover property (@(posedge clk) disable iff (reset)
            check_en && cen6 && exp_lhbl && exp_lvbl && m_sel[1:0] == g);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("timeout: the run did not finish within the watchdog limit");
    end

    // stimulus in one process so the lfsr order is fixed
    initial begin
        logic [31:0] bits;
        int          k;
        lfsr       = 32'h7b9c;
        pixels     = '0;
        prog_valid = 1'b0;
        prog_data  = '0;
        for (k = 0; k < LOAD_LEN; k++) begin
            draw_bits(4, bits);
            ref_prom[k / 256][k % 256] = bits[3:0];
        end
        @(negedge reset);
        while (video_pulses < RUN_PULSES) begin
            @(posedge clk);
            #2;
            if (xfer_count < LOAD_LEN) begin
                draw_bits(1, bits);
                prog_valid = bits[0];                        // random gaps
                prog_data  = ref_prom[xfer_count / 256][xfer_count % 256];
            end else begin
                prog_valid = 1'b0;
            end
            if (cen6) begin
                draw_bits(22, bits);
                pixels = bits[21:0];                         // new layers every pixel
            end
        end
        @(posedge clk);
        if (sel_seen == 4'hf) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abort_run($sformatf("select codes seen %b, not all four occurred", sel_seen));
        end
    end

endmodule

//--- source/prom_loader.sv
// turns the nibble programming stream into writes for the four palette and select proms
`timescale 1ns/100ps

module prom_loader (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    prog_valid,
    input  colmix_pkg::colour_t     prog_data,
    output logic                    prog_ready,
    output colmix_pkg::prom_write_t prom_wr,
    output logic                    load_done
);

    colmix_pkg::load_state_t state;
    colmix_pkg::load_index_t index;   // nibble k -> prom k/256, addr k%256
    logic                    xfer;    // handshake completes this edge

    assign prog_ready = (state == colmix_pkg::LOAD_RUN);
    assign load_done  = (state == colmix_pkg::LOAD_DONE);
    assign xfer       = prog_valid & prog_ready;

    // write goes out on the transfer edge itself, no cen gating
    always_comb begin
        prom_wr.addr = index[colmix_pkg::PROM_AW-1:0];
        prom_wr.data = prog_data;
        prom_wr.we   = '0;
        if (xfer) begin
            // upper index bits pick red, green, blue, select
            prom_wr.we[index[colmix_pkg::LOAD_IW-1:colmix_pkg::PROM_AW]] = 1'b1;
        end
    end

    // index counter and fsm
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= colmix_pkg::LOAD_RUN;
            index <= '0;
        end else begin
            case (state)
                colmix_pkg::LOAD_RUN: begin
                    if (xfer) begin
                        index <= index + 1'b1;
                        if (index == colmix_pkg::LOAD_LAST) begin
                            state <= colmix_pkg::LOAD_DONE;   // select prom full
                        end
                    end
                end
                colmix_pkg::LOAD_DONE: begin
                    state <= colmix_pkg::LOAD_DONE;           // stays until reset
                end
                default: begin
                    state <= colmix_pkg::LOAD_RUN;
                end
            endcase
        end
    end

endmodule

//--- source/video_colmix_top.sv
// top of the colour mixing subsystem, connects timing, prom loader and mixer
`timescale 1ns/100ps

module video_colmix_top #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 256,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224
) (
    input  logic                      clk,
    input  logic                      reset,
    input  colmix_pkg::layer_pixels_t pixels,        // from tile and sprite generators
    input  logic                      prog_valid,
    input  colmix_pkg::colour_t       prog_data,
    output logic                      prog_ready,
    output logic                      load_done,
    output logic                      cen6,
    output colmix_pkg::video_sync_t   sync,
    output colmix_pkg::rgb_t          rgb
);

    colmix_pkg::prom_write_t prom_wr;               // loader -> prom write port

    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE)
    ) u_timing (
        .clk     (clk),
        .reset   (reset),
        .cen6    (cen6),
        .sync    (sync),
        .h_count (),                                // counts only feed the flags here
        .v_count ()
    );

    prom_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .prog_valid (prog_valid),
        .prog_data  (prog_data),
        .prog_ready (prog_ready),
        .prom_wr    (prom_wr),
        .load_done  (load_done)
    );

    colour_mixer u_mixer (
        .clk     (clk),
        .reset   (reset),
        .cen6    (cen6),
        .pixels  (pixels),
        .sync    (sync),
        .prom_wr (prom_wr),
        .rgb     (rgb)
    );

endmodule

//--- source/video_timing.sv
// pixel clock enable and h/v counters with blanking flags, instantiated by the colour mixing top
`timescale 1ns/100ps

module video_timing #(
    parameter int H_TOTAL  = 384,     // pixels per line
    parameter int H_ACTIVE = 256,     // visible pixels per line
    parameter int V_TOTAL  = 262,     // lines per frame
    parameter int V_ACTIVE = 224      // visible lines per frame
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    cen6,
    output colmix_pkg::video_sync_t sync,
    output logic [8:0]              h_count,
    output logic [8:0]              v_count
);

    logic [1:0] div;                  // free running clk divider
    logic       h_wrap;               // last pixel of the line
    logic       v_wrap;               // last line of the frame
    logic [8:0] h_next;
    logic [8:0] v_next;

    // one clk in four, first pulse right after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            div  <= 2'd0;
            cen6 <= 1'b0;
        end else begin
            div  <= div + 2'd1;
            cen6 <= (div == 2'd0);    // registered, so no glitch on the enable
        end
    end

    // next count values
    always_comb begin
        h_wrap = (h_count == 9'(H_TOTAL - 1));
        v_wrap = (v_count == 9'(V_TOTAL - 1));
        h_next = h_wrap ? 9'd0 : h_count + 9'd1;
        v_next = v_count;                          // holds mid line
        if (h_wrap) begin
            v_next = v_wrap ? 9'd0 : v_count + 9'd1;
        end
    end

    // counters and flags step together on the pixel enable
    always_ff @(posedge clk) begin
        if (reset) begin
            h_count   <= 9'd0;
            v_count   <= 9'd0;
            sync.lhbl <= 1'b1;        // count 0 is inside the active area
            sync.lvbl <= 1'b1;
        end else if (cen6) begin
            h_count   <= h_next;
            v_count   <= v_next;
            sync.lhbl <= (h_next < 9'(H_ACTIVE));
            sync.lvbl <= (v_next < 9'(V_ACTIVE));
        end
    end

endmodule

//--- verilog.f
common/colmix_pkg.sv
source/video_timing.sv
source/prom_loader.sv
colmix/palette_prom.sv
colmix/colour_mixer.sv
source/video_colmix_top.sv
sim/tb_clock.sv
sim/tb_colmix.sv
